// File: Makefile
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= dcache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dcache.f
hdl/dcache_pkg.sv
hdl/line_xfer_if.sv
hdl/cache_bank.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/cache_ctrl.sv
hdl/mem_master.sv
hdl/dcache_top.sv
verif/mem_model.sv
verif/tb_dcache.sv

// File: hdl/cache_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Simple dual-port RAM, one write and one read
// Read data appears one cycle after the read address
// A read of the address being written returns the old data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_bank #(
	parameter int DATA_W_P = 32,
	parameter int ADDR_W_P = 4
) (
	input  logic                clk,
	input  logic                i_we,
	input  logic [ADDR_W_P-1:0] i_waddr,
	input  logic [DATA_W_P-1:0] i_wdata,
	input  logic [ADDR_W_P-1:0] i_raddr,
	output logic [DATA_W_P-1:0] o_rdata
);

	logic [DATA_W_P-1:0] mem [2**ADDR_W_P];

	// Maps onto block RAM with a registered output
	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
		o_rdata <= mem[i_raddr];
	end

endmodule

`default_nettype wire

// File: hdl/cache_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Processor-side Wishbone classic slave and miss FSM
// Address must stay stable on the bus until the ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
	parameter int OFFSET_W = 2
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_wb_cyc,
	input  logic              i_wb_stb,
	input  logic              i_wb_we,
	input  logic              i_hit,
	input  logic              i_victim_dirty,
	input  dcache_pkg::addr_t i_victim_base,
	input  dcache_pkg::addr_t i_req_addr,
	output logic              o_wb_ack,
	output logic              o_mark_dirty,
	output logic              o_store,
	output logic              o_capture,
	output logic              o_shift,
	output logic              o_fill_done,
	line_xfer_if.initiator    xfer
);

	localparam int LSB_W = OFFSET_W + dcache_pkg::BYTE_OFF_W;

	typedef enum logic [1:0] {
		ST_READY,
		ST_FLUSH,
		ST_REFILL
	} state_t;

	state_t            state;
	logic              lookup_q;
	logic              hit_ok;
	logic              miss;
	dcache_pkg::addr_t refill_base;

	// lookup_q marks the cycle in which the bank outputs belong to the request
	assign hit_ok = (state == ST_READY) && lookup_q && i_hit;
	assign miss   = (state == ST_READY) && lookup_q && !i_hit;

	assign refill_base = {i_req_addr[dcache_pkg::ADDR_W-1:LSB_W], {LSB_W{1'b0}}};

	assign o_store      = hit_ok && i_wb_we;
	assign o_mark_dirty = hit_ok && i_wb_we;
	assign o_capture    = miss && i_victim_dirty;
	assign o_shift      = (state == ST_FLUSH) && xfer.word_valid;
	assign o_fill_done  = (state == ST_REFILL) && xfer.done;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state         <= ST_READY;
			lookup_q      <= 1'b0;
			o_wb_ack      <= 1'b0;
			xfer.start    <= 1'b0;
			xfer.is_write <= 1'b0;
		end else begin
			// No new lookup while the ack is out or a miss is in progress
			lookup_q   <= (state == ST_READY) && i_wb_cyc && i_wb_stb
				&& !o_wb_ack && !lookup_q;
			o_wb_ack   <= hit_ok;
			xfer.start <= 1'b0;

			case (state)
				ST_READY: begin
					if (miss) begin
						xfer.start    <= 1'b1;
						xfer.is_write <= i_victim_dirty;
						state         <= i_victim_dirty ? ST_FLUSH : ST_REFILL;
					end
				end

				ST_FLUSH: begin
					if (xfer.done) begin
						xfer.start    <= 1'b1;
						xfer.is_write <= 1'b0;
						state         <= ST_REFILL;
					end
				end

				ST_REFILL: begin
					// Back to READY, the held request is looked up again
					if (xfer.done) begin
						state <= ST_READY;
					end
				end

				default: begin
					state <= ST_READY;
				end
			endcase
		end
	end

	// Line address for the next transfer
	always_ff @(posedge clk) begin
		if (miss) begin
			xfer.line_base <= i_victim_dirty ? i_victim_base : refill_base;
		end else if (state == ST_FLUSH && xfer.done) begin
			xfer.line_base <= refill_base;
		end
	end

endmodule

`default_nettype wire

// File: hdl/data_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One word column per word of the line, indexed by line
// Load data is valid the cycle after the lookup address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module data_store #(
	parameter int INDEX_W  = 4,
	parameter int OFFSET_W = 2
) (
	input  logic                clk,
	input  dcache_pkg::addr_t   i_lookup_addr,
	input  logic                i_store,
	input  dcache_pkg::word_t   i_store_data,
	input  logic                i_fill,
	input  logic [OFFSET_W-1:0] i_fill_idx,
	input  dcache_pkg::word_t   i_fill_word,
	input  logic                i_capture,
	input  logic                i_shift,
	output dcache_pkg::word_t   o_load_data,
	output dcache_pkg::word_t   o_flush_word
);

	localparam int LINE_WORDS = 2 ** OFFSET_W;
	localparam int LSB_W      = OFFSET_W + dcache_pkg::BYTE_OFF_W;

	logic [INDEX_W-1:0]    lookup_index;
	logic [INDEX_W-1:0]    req_index;
	logic [OFFSET_W-1:0]   req_offset;
	logic [LINE_WORDS-1:0] col_we;
	dcache_pkg::word_t     col_wdata;
	dcache_pkg::word_t     col_rdata [LINE_WORDS];
	dcache_pkg::word_t     flush_sr [LINE_WORDS];

	assign lookup_index = i_lookup_addr[LSB_W +: INDEX_W];

	always_ff @(posedge clk) begin
		req_index  <= lookup_index;
		req_offset <= i_lookup_addr[dcache_pkg::BYTE_OFF_W +: OFFSET_W];
	end

	// Refill words take priority, a store never overlaps a refill
	always_comb begin
		col_we = '0;
		if (i_fill) begin
			col_we[i_fill_idx] = 1'b1;
		end else if (i_store) begin
			col_we[req_offset] = 1'b1;
		end
	end

	assign col_wdata = i_fill ? i_fill_word : i_store_data;

	for (genvar g = 0; g < LINE_WORDS; g++) begin : g_col
		cache_bank #(
			.DATA_W_P (dcache_pkg::DATA_W),
			.ADDR_W_P (INDEX_W)
		) col_bank_i (
			.clk     (clk),
			.i_we    (col_we[g]),
			.i_waddr (req_index),
			.i_wdata (col_wdata),
			.i_raddr (lookup_index),
			.o_rdata (col_rdata[g])
		);
	end

	assign o_load_data = col_rdata[req_offset];

	// Victim line, word 0 first, one step per acknowledged write
	always_ff @(posedge clk) begin
		if (i_capture) begin
			for (int i = 0; i < LINE_WORDS; i++) begin
				flush_sr[i] <= col_rdata[i];
			end
		end else if (i_shift) begin
			for (int i = 0; i < LINE_WORDS - 1; i++) begin
				flush_sr[i] <= flush_sr[i+1];
			end
		end
	end

	assign o_flush_word = flush_sr[0];

endmodule

`default_nettype wire

// File: hdl/dcache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths shared by the cache and its testbench
// Byte addresses, whole 32-bit words only, no byte selects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package dcache_pkg;

	// Data word and byte address
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;

	// Address bits below the word
	localparam int BYTE_OFF_W = 2;

	// Longest line the memory side can move
	localparam int MAX_LINE_WORDS = 16;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// File: hdl/dcache_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped write-back data cache, Wishbone classic on both sides
// Hits ack on the second edge after stb, misses take longer
// Lines of 2 to 16 words, whole 32-bit words only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
	parameter int INDEX_W  = 4,
	parameter int OFFSET_W = 2
) (
	input  logic              clk,
	input  logic              rst_n,
	// Processor side
	input  logic              i_wb_cyc,
	input  logic              i_wb_stb,
	input  logic              i_wb_we,
	input  dcache_pkg::addr_t i_wb_adr,
	input  dcache_pkg::word_t i_wb_dat,
	output logic              o_wb_ack,
	output dcache_pkg::word_t o_wb_dat,
	// Memory side
	output logic              o_mem_cyc,
	output logic              o_mem_stb,
	output logic              o_mem_we,
	output dcache_pkg::addr_t o_mem_adr,
	output dcache_pkg::word_t o_mem_dat,
	input  dcache_pkg::word_t i_mem_dat,
	input  logic              i_mem_ack
);

	// Refuse shapes the memory side or the address cannot hold
	if (OFFSET_W < 1 || (2 ** OFFSET_W) > dcache_pkg::MAX_LINE_WORDS
		|| INDEX_W + OFFSET_W + dcache_pkg::BYTE_OFF_W >= dcache_pkg::ADDR_W) begin : g_bad_cfg
		$fatal(1, "dcache_top: unsupported INDEX_W/OFFSET_W");
	end

	logic              hit;
	logic              victim_dirty;
	dcache_pkg::addr_t victim_base;
	logic              mark_dirty;
	logic              store;
	logic              capture;
	logic              shift;
	logic              fill_done;

	line_xfer_if #(.OFFSET_W(OFFSET_W)) xfer ();

	// The held bus address feeds the banks every cycle
	tag_store #(
		.INDEX_W  (INDEX_W),
		.OFFSET_W (OFFSET_W)
	) tag_store_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_lookup_addr  (i_wb_adr),
		.i_fill_done    (fill_done),
		.i_fill_addr    (xfer.line_base),
		.i_mark_dirty   (mark_dirty),
		.o_hit          (hit),
		.o_victim_dirty (victim_dirty),
		.o_victim_base  (victim_base)
	);

	data_store #(
		.INDEX_W  (INDEX_W),
		.OFFSET_W (OFFSET_W)
	) data_store_i (
		.clk           (clk),
		.i_lookup_addr (i_wb_adr),
		.i_store       (store),
		.i_store_data  (i_wb_dat),
		.i_fill        (xfer.word_valid && !xfer.is_write),
		.i_fill_idx    (xfer.word_idx),
		.i_fill_word   (xfer.rd_word),
		.i_capture     (capture),
		.i_shift       (shift),
		.o_load_data   (o_wb_dat),
		.o_flush_word  (xfer.wr_word)
	);

	cache_ctrl #(
		.OFFSET_W (OFFSET_W)
	) cache_ctrl_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_wb_cyc       (i_wb_cyc),
		.i_wb_stb       (i_wb_stb),
		.i_wb_we        (i_wb_we),
		.i_hit          (hit),
		.i_victim_dirty (victim_dirty),
		.i_victim_base  (victim_base),
		.i_req_addr     (i_wb_adr),
		.o_wb_ack       (o_wb_ack),
		.o_mark_dirty   (mark_dirty),
		.o_store        (store),
		.o_capture      (capture),
		.o_shift        (shift),
		.o_fill_done    (fill_done),
		.xfer           (xfer.initiator)
	);

	mem_master #(
		.OFFSET_W (OFFSET_W)
	) mem_master_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.xfer      (xfer.target),
		.o_mem_cyc (o_mem_cyc),
		.o_mem_stb (o_mem_stb),
		.o_mem_we  (o_mem_we),
		.o_mem_adr (o_mem_adr),
		.o_mem_dat (o_mem_dat),
		.i_mem_dat (i_mem_dat),
		.i_mem_ack (i_mem_ack)
	);

endmodule

`default_nettype wire

// File: hdl/line_xfer_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line transfer between controller and memory master
// start is a one-cycle pulse, accepted only while the master is idle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface line_xfer_if #(
	parameter int OFFSET_W = 2
) ();

	// Request from the controller
	logic start;
	logic is_write;
	dcache_pkg::addr_t line_base;

	// Flush data, presented one word at a time
	dcache_pkg::word_t wr_word;

	// Word traffic from the master
	logic [OFFSET_W-1:0] word_idx;
	logic word_valid;
	dcache_pkg::word_t rd_word;
	logic done;

	modport initiator (
		output start, is_write, line_base, wr_word,
		input  word_idx, word_valid, rd_word, done
	);

	modport target (
		input  start, is_write, line_base, wr_word,
		output word_idx, word_valid, rd_word, done
	);

endinterface

`default_nettype wire

// File: hdl/mem_master.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic master for one cache line
// One word per cycle, stb low for a cycle between words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mem_master #(
	parameter int OFFSET_W = 2
) (
	input  logic              clk,
	input  logic              rst_n,
	line_xfer_if.target       xfer,
	output logic              o_mem_cyc,
	output logic              o_mem_stb,
	output logic              o_mem_we,
	output dcache_pkg::addr_t o_mem_adr,
	output dcache_pkg::word_t o_mem_dat,
	input  dcache_pkg::word_t i_mem_dat,
	input  logic              i_mem_ack
);

	localparam int LINE_WORDS = 2 ** OFFSET_W;
	localparam int LSB_W      = OFFSET_W + dcache_pkg::BYTE_OFF_W;

	logic [OFFSET_W-1:0] word_cnt;
	logic                last_word;
	logic                word_ack;
	logic                we_q;
	dcache_pkg::addr_t   base_q;

	assign word_ack  = o_mem_stb && i_mem_ack;
	assign last_word = (word_cnt == OFFSET_W'(LINE_WORDS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mem_cyc <= 1'b0;
			o_mem_stb <= 1'b0;
			word_cnt  <= '0;
		end else if (!o_mem_cyc) begin
			if (xfer.start) begin
				o_mem_cyc <= 1'b1;
				o_mem_stb <= 1'b1;
				word_cnt  <= '0;
			end
		end else if (o_mem_stb) begin
			// Wait for the ack as long as it takes
			if (i_mem_ack) begin
				o_mem_stb <= 1'b0;
				if (last_word) begin
					o_mem_cyc <= 1'b0;
				end else begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
		end else begin
			o_mem_stb <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!o_mem_cyc && xfer.start) begin
			base_q <= xfer.line_base;
			we_q   <= xfer.is_write;
		end
	end

	assign o_mem_we  = we_q;
	assign o_mem_adr = {base_q[dcache_pkg::ADDR_W-1:LSB_W], word_cnt,
		{dcache_pkg::BYTE_OFF_W{1'b0}}};
	assign o_mem_dat = xfer.wr_word;

	assign xfer.word_idx   = word_cnt;
	assign xfer.word_valid = word_ack;
	assign xfer.rd_word    = i_mem_dat;
	assign xfer.done       = word_ack && last_word;

endmodule

`default_nettype wire

// File: hdl/tag_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tags, valid and dirty bits of a direct-mapped cache
// Results are valid the cycle after the lookup address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tag_store #(
	parameter int INDEX_W  = 4,
	parameter int OFFSET_W = 2
) (
	input  logic              clk,
	input  logic              rst_n,
	input  dcache_pkg::addr_t i_lookup_addr,
	input  logic              i_fill_done,
	input  dcache_pkg::addr_t i_fill_addr,
	input  logic              i_mark_dirty,
	output logic              o_hit,
	output logic              o_victim_dirty,
	output dcache_pkg::addr_t o_victim_base
);

	localparam int LSB_W = OFFSET_W + dcache_pkg::BYTE_OFF_W;
	localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - LSB_W;
	localparam int DEPTH = 2 ** INDEX_W;

	logic [INDEX_W-1:0] lookup_index;
	logic [INDEX_W-1:0] req_index;
	logic [INDEX_W-1:0] fill_index;
	logic [TAG_W-1:0]   req_tag;
	logic [TAG_W-1:0]   fill_tag;
	logic [TAG_W-1:0]   stored_tag;
	logic [DEPTH-1:0]   valid_bits;
	logic [DEPTH-1:0]   dirty_bits;

	assign lookup_index = i_lookup_addr[LSB_W +: INDEX_W];
	assign fill_index   = i_fill_addr[LSB_W +: INDEX_W];
	assign fill_tag     = i_fill_addr[dcache_pkg::ADDR_W-1 -: TAG_W];

	// Request tag and index line up with the bank output
	always_ff @(posedge clk) begin
		req_index <= lookup_index;
		req_tag   <= i_lookup_addr[dcache_pkg::ADDR_W-1 -: TAG_W];
	end

	cache_bank #(
		.DATA_W_P (TAG_W),
		.ADDR_W_P (INDEX_W)
	) tag_bank_i (
		.clk     (clk),
		.i_we    (i_fill_done),
		.i_waddr (fill_index),
		.i_wdata (fill_tag),
		.i_raddr (lookup_index),
		.o_rdata (stored_tag)
	);

	// A refilled line starts clean
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (i_fill_done) begin
			valid_bits[fill_index] <= 1'b1;
			dirty_bits[fill_index] <= 1'b0;
		end else if (i_mark_dirty) begin
			dirty_bits[req_index] <= 1'b1;
		end
	end

	assign o_hit          = valid_bits[req_index] && (stored_tag == req_tag);
	assign o_victim_dirty = valid_bits[req_index] && dirty_bits[req_index];

	// Old line address rebuilt from the stored tag
	assign o_victim_base = {stored_tag, req_index, {LSB_W{1'b0}}};

endmodule

`default_nettype wire

// File: verif/mem_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic memory slave for simulation only
// Ack comes i_ack_delay cycles after the first possible one
// Addresses wrap modulo the memory size
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
	parameter int MEM_WORDS = 1024
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_cyc,
	input  logic              i_stb,
	input  logic              i_we,
	input  dcache_pkg::addr_t i_adr,
	input  dcache_pkg::word_t i_dat,
	input  logic [3:0]        i_ack_delay,
	output dcache_pkg::word_t o_dat,
	output logic              o_ack
);

	localparam int AW = $clog2(MEM_WORDS);

	// Preloaded by the testbench before reset
	dcache_pkg::word_t mem [MEM_WORDS];

	logic [AW-1:0] idx;
	logic [3:0]    wait_cnt;

	assign idx = i_adr[AW+1:2];

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_ack    <= 1'b0;
			o_dat    <= '0;
			wait_cnt <= '0;
		end else begin
			o_ack <= 1'b0;
			// No second ack while the master is still dropping stb
			if (i_cyc && i_stb && !o_ack) begin
				if (wait_cnt >= i_ack_delay) begin
					o_ack    <= 1'b1;
					wait_cnt <= '0;
					if (i_we) begin
						mem[idx] = i_dat;
					end else begin
						o_dat <= mem[idx];
					end
				end else begin
					wait_cnt <= wait_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_dcache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests for the data cache, 16 lines of 4 words
// Stops at the first error
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

	localparam int INDEX_W     = 4;
	localparam int OFFSET_W    = 2;
	localparam int LINE_WORDS  = 2 ** OFFSET_W;
	localparam int CACHE_BYTES = (2 ** INDEX_W) * LINE_WORDS * 4;
	localparam int MEM_WORDS   = 1024;
	localparam int MEM_AW      = $clog2(MEM_WORDS);
	localparam int RAND_OPS    = 200;
	localparam int ACK_TIMEOUT = 200;
	localparam int HIT_EDGES   = 2;

	// Line A and line B share an index
	localparam dcache_pkg::addr_t LINE_A = 32'h0000_0040;
	localparam dcache_pkg::addr_t LINE_B = LINE_A + CACHE_BYTES;

	logic              clk;
	logic              rst_n;
	logic              wb_cyc;
	logic              wb_stb;
	logic              wb_we;
	dcache_pkg::addr_t wb_adr;
	dcache_pkg::word_t wb_wdat;
	logic              wb_ack;
	dcache_pkg::word_t wb_rdat;
	logic              mem_cyc;
	logic              mem_stb;
	logic              mem_we;
	dcache_pkg::addr_t mem_adr;
	dcache_pkg::word_t mem_wdat;
	dcache_pkg::word_t mem_rdat;
	logic              mem_ack;
	logic [3:0]        ack_delay;
	logic [31:0]       rng;

	dcache_pkg::word_t shadow [MEM_WORDS];
	dcache_pkg::addr_t log_adr [$];
	logic              log_we [$];
	dcache_pkg::word_t log_dat [$];

	dcache_top #(
		.INDEX_W  (INDEX_W),
		.OFFSET_W (OFFSET_W)
	) dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_wb_cyc  (wb_cyc),
		.i_wb_stb  (wb_stb),
		.i_wb_we   (wb_we),
		.i_wb_adr  (wb_adr),
		.i_wb_dat  (wb_wdat),
		.o_wb_ack  (wb_ack),
		.o_wb_dat  (wb_rdat),
		.o_mem_cyc (mem_cyc),
		.o_mem_stb (mem_stb),
		.o_mem_we  (mem_we),
		.o_mem_adr (mem_adr),
		.o_mem_dat (mem_wdat),
		.i_mem_dat (mem_rdat),
		.i_mem_ack (mem_ack)
	);

	mem_model #(
		.MEM_WORDS (MEM_WORDS)
	) mem_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_cyc       (mem_cyc),
		.i_stb       (mem_stb),
		.i_we        (mem_we),
		.i_adr       (mem_adr),
		.i_dat       (mem_wdat),
		.i_ack_delay (ack_delay),
		.o_dat       (mem_rdat),
		.o_ack       (mem_ack)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Memory bus monitor, stb and ack are settled at the falling edge
	always @(negedge clk) begin
		if (mem_stb && !mem_cyc) begin
			fail_run("memory strobe raised outside a bus cycle");
		end
		if (mem_stb && mem_ack) begin
			log_adr.push_back(mem_adr);
			log_we.push_back(mem_we);
			log_dat.push_back(mem_we ? mem_wdat : mem_rdat);
			rng = xorshift(rng);
			ack_delay = {2'b00, rng[1:0]};
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input dcache_pkg::word_t got,
		input dcache_pkg::word_t exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input dcache_pkg::addr_t got,
		input dcache_pkg::addr_t exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic log_clear();
		log_adr.delete();
		log_we.delete();
		log_dat.delete();
	endtask

	// One processor request, edges counts clock edges until the ack
	task automatic bus_access(input logic we, input dcache_pkg::addr_t adr,
		input dcache_pkg::word_t wdat, output dcache_pkg::word_t rdat, output int edges);
		@(posedge clk);
		#1;
		// Ack of the previous request lasts one cycle only
		check_bit("o_wb_ack", wb_ack, 1'b0);
		wb_cyc  = 1'b1;
		wb_stb  = 1'b1;
		wb_we   = we;
		wb_adr  = adr;
		wb_wdat = wdat;
		edges   = 0;
		do begin
			@(posedge clk);
			#1;
			edges++;
		end while (!wb_ack && edges < ACK_TIMEOUT);
		if (!wb_ack) begin
			fail_run($sformatf("no ack within %0d cycles for address %h", ACK_TIMEOUT, adr));
		end
		// Any line transfer is over by the time of the ack
		check_bit("o_mem_cyc", mem_cyc, 1'b0);
		rdat   = wb_rdat;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic load_check(input dcache_pkg::addr_t adr, output int edges);
		dcache_pkg::word_t rdat;
		bus_access(1'b0, adr, '0, rdat, edges);
		check_word($sformatf("o_wb_dat @%h", adr), rdat, shadow[adr[MEM_AW+1:2]]);
	endtask

	task automatic store_word(input dcache_pkg::addr_t adr, input dcache_pkg::word_t wdat,
		output int edges);
		dcache_pkg::word_t rdat_ignored;
		bus_access(1'b1, adr, wdat, rdat_ignored, edges);
		shadow[adr[MEM_AW+1:2]] = wdat;
	endtask

	// Logged words first .. first+LINE_WORDS-1 must cover one line in order
	task automatic check_line_xfer(input int first, input logic we, input dcache_pkg::addr_t base);
		dcache_pkg::addr_t adr;
		for (int k = 0; k < LINE_WORDS; k++) begin
			adr = base + dcache_pkg::addr_t'(4 * k);
			check_addr("o_mem_adr", log_adr[first+k], adr);
			check_bit("o_mem_we", log_we[first+k], we);
			if (we) begin
				check_word("o_mem_dat", log_dat[first+k], shadow[adr[MEM_AW+1:2]]);
			end
		end
	endtask

	task automatic cold_load_miss();
		int edges;
		log_clear();
		load_check(LINE_A + 8, edges);
		check_count("memory cycles", log_adr.size(), LINE_WORDS);
		check_line_xfer(0, 1'b0, LINE_A);
	endtask

	task automatic repeat_load_hit();
		int edges;
		log_clear();
		load_check(LINE_A + 12, edges);
		check_count("hit ack edge", edges, HIT_EDGES);
		check_count("memory cycles", log_adr.size(), 0);
	endtask

	task automatic store_then_load();
		int edges;
		log_clear();
		rng = xorshift(rng);
		store_word(LINE_A + 8, rng, edges);
		check_count("store ack edge", edges, HIT_EDGES);
		load_check(LINE_A + 8, edges);
		check_count("hit ack edge", edges, HIT_EDGES);
		check_count("memory cycles", log_adr.size(), 0);
	endtask

	// Dirty line A is written back before line B comes in
	task automatic conflict_evict();
		int edges;
		log_clear();
		load_check(LINE_B + 4, edges);
		check_count("memory cycles", log_adr.size(), 2 * LINE_WORDS);
		check_line_xfer(0, 1'b1, LINE_A);
		check_line_xfer(LINE_WORDS, 1'b0, LINE_B);
		for (int i = 0; i < MEM_WORDS; i++) begin
			check_word($sformatf("mem[%0d]", i), mem_i.mem[i], shadow[i]);
		end
	endtask

	// Word addresses over four times the cache size
	task automatic random_traffic();
		int edges;
		logic we;
		dcache_pkg::addr_t adr;
		for (int n = 0; n < RAND_OPS; n++) begin
			rng = xorshift(rng);
			adr = rng & dcache_pkg::addr_t'(4 * CACHE_BYTES - 4);
			we  = rng[16];
			rng = xorshift(rng);
			if (we) begin
				store_word(adr, rng, edges);
			end else begin
				load_check(adr, edges);
			end
		end
	endtask

	initial begin
		rng       = 32'h7d2e_f4ab;
		rst_n     = 1'b0;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_wdat   = '0;
		ack_delay = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			rng = xorshift(rng);
			shadow[i] = rng;
			mem_i.mem[i] = rng;
		end
		repeat (5) @(posedge clk);
		#1;
		check_bit("o_wb_ack", wb_ack, 1'b0);
		check_bit("o_mem_cyc", mem_cyc, 1'b0);
		check_bit("o_mem_stb", mem_stb, 1'b0);
		rst_n = 1'b1;

		cold_load_miss();
		repeat_load_hit();
		store_then_load();
		conflict_evict();
		random_traffic();

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire
